// ==== rtl/arena_pkg.sv ====
// Arena geometry, tile codes, stat limits and shared types that every rtl module imports.
package arena_pkg;

	typedef logic [8:0] coord_t;	// screen pixel coordinate.
	typedef logic [1:0] stat_t;
	typedef logic [1:0] lives_t;
	typedef logic [3:0] speed_t;	// pixels per move tick.

	typedef enum logic [3:0] {
		TILE_EMPTY      = 4'd0,
		TILE_WALL       = 4'd1,
		TILE_BRICK      = 4'd2,
		TILE_PU_BOMB    = 4'd3,
		TILE_PU_RADIUS  = 4'd4,
		TILE_PU_POTENCY = 4'd5,
		TILE_PU_THROW   = 4'd6,	// picked up, no effect yet.
		TILE_PU_LIFE    = 4'd7,
		TILE_PU_SPEED   = 4'd8,
		TILE_HEART      = 4'd9,
		TILE_BOMB       = 4'd10,
		TILE_EXPLOSION  = 4'd11,
		TILE_P1         = 4'd12,
		TILE_P2         = 4'd13,
		TILE_P1_INV     = 4'd14,
		TILE_P2_INV     = 4'd15
	} tile_id_t;

	localparam coord_t ARENA_X_MIN = 9'd72;
	localparam coord_t ARENA_X_MAX = 9'd232;
	localparam coord_t ARENA_Y_MIN = 9'd32;
	localparam coord_t ARENA_Y_MAX = 9'd192;
	localparam coord_t P1_START_X  = 9'd88;
	localparam coord_t P2_START_X  = 9'd216;
	localparam coord_t START_Y     = 9'd112;
	localparam coord_t SPRITE_EDGE = 9'd15;	// top-left to far pixel.

	localparam lives_t START_LIVES = 2'd3;
	localparam lives_t LIFE_CAP    = 2'd3;
	localparam speed_t START_SPEED = 4'd4;
	localparam speed_t SPEED_LIMIT = 4'd8;
	localparam stat_t  STAT_LIMIT  = 2'd2;	// bombs, radius and potency.
	localparam int     CORNERS     = 8;	// probe points per player.

endpackage

// ==== rtl/coordinate_counter.sv ====
// One axis of a player position, stepped by the player speed inside fixed bounds.
module coordinate_counter #(
	parameter arena_pkg::coord_t START = 9'd0,
	parameter arena_pkg::coord_t MIN = 9'd0,
	parameter arena_pkg::coord_t MAX = 9'd511
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic direction,	// 1 counts up.
	input arena_pkg::speed_t step,
	output arena_pkg::coord_t coord
);
	import arena_pkg::*;

	coord_t step_ext;

	assign step_ext = coord_t'(step);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			coord <= START;
		else if (enable)
		begin
			if (direction)
			begin
				if (coord <= MAX - step_ext)	// whole step must fit.
					coord <= coord + step_ext;
			end
			else if (coord >= MIN + step_ext)
				coord <= coord - step_ext;
		end
	end

endmodule

// ==== rtl/player_mover.sv ====
// Position of one player, moved on each move tick when the keys and corner probes allow it.
module player_mover #(
	parameter arena_pkg::coord_t START_X = arena_pkg::P1_START_X
) (
	input logic clock,
	input logic reset,
	input logic move_tick,
	input logic xmov,
	input logic xdir,	// 1 is +x.
	input logic ymov,
	input logic ydir,	// 1 is +y.
	input logic [arena_pkg::CORNERS-1:0] passable,
	input arena_pkg::speed_t speed,
	output arena_pkg::coord_t pos_x,
	output arena_pkg::coord_t pos_y
);
	import arena_pkg::*;

	logic x_open;	// both leading corners free.
	logic y_open;
	logic x_enable;
	logic y_enable;

	assign x_open = xdir ? (passable[6] & passable[7]) : (passable[4] & passable[5]);
	assign y_open = ydir ? (passable[2] & passable[3]) : (passable[0] & passable[1]);
	assign x_enable = move_tick & xmov & x_open;
	assign y_enable = move_tick & ymov & y_open;

	coordinate_counter #(.START(START_X), .MIN(ARENA_X_MIN), .MAX(ARENA_X_MAX)) x_counter (
		.clock, .reset, .enable(x_enable), .direction(xdir), .step(speed), .coord(pos_x)
	);

	coordinate_counter #(.START(START_Y), .MIN(ARENA_Y_MIN), .MAX(ARENA_Y_MAX)) y_counter (
		.clock, .reset, .enable(y_enable), .direction(ydir), .step(speed), .coord(pos_y)
	);

	// sprite stays inside the arena whatever the speed.
	in_bounds: assert property (@(posedge clock) disable iff (reset)
		pos_x >= ARENA_X_MIN && pos_x <= ARENA_X_MAX &&
		pos_y >= ARENA_Y_MIN && pos_y <= ARENA_Y_MAX);

endmodule

// ==== rtl/corner_prober.sv ====
// Sequencer that probes the eight corner points of both players over the tile map handshake.
module corner_prober (
	input logic clock,
	input logic reset,
	input arena_pkg::coord_t p1_x,
	input arena_pkg::coord_t p1_y,
	input arena_pkg::coord_t p2_x,
	input arena_pkg::coord_t p2_y,
	input logic probe_ack,
	input arena_pkg::tile_id_t probe_tile,
	input logic probe_blast,
	output logic probe_req,
	output arena_pkg::coord_t probe_x,
	output arena_pkg::coord_t probe_y,
	output logic tile_clear,
	output arena_pkg::coord_t clear_x,
	output arena_pkg::coord_t clear_y,
	output logic [arena_pkg::CORNERS-1:0] p1_passable,
	output logic [arena_pkg::CORNERS-1:0] p2_passable,
	output logic p1_result_valid,
	output logic p2_result_valid,
	output arena_pkg::tile_id_t result_tile,
	output logic result_blast
);
	import arena_pkg::*;

	localparam int CW = $clog2(CORNERS);

	typedef enum logic [1:0] {S_LOAD, S_WAIT_ACK, S_RELEASE, S_ADVANCE} state_t;

	state_t state;
	logic player;	// 0 is player 1.
	logic [CW-1:0] corner;
	coord_t base_x;
	coord_t base_y;
	coord_t point_x;
	coord_t point_y;
	logic pu_tile;
	logic open_tile;

	assign base_x = player ? p2_x : p1_x;
	assign base_y = player ? p2_y : p1_y;

	always_comb
	begin
		if (corner[2])
		begin	// left and right columns.
			point_x = corner[1] ? base_x + coord_t'(SPRITE_EDGE + 1) : base_x - coord_t'(1);
			point_y = corner[0] ? base_y + SPRITE_EDGE : base_y;
		end
		else
		begin	// rows above and below.
			point_x = corner[0] ? base_x + SPRITE_EDGE : base_x;
			point_y = corner[1] ? base_y + coord_t'(SPRITE_EDGE + 1) : base_y - coord_t'(1);
		end
	end

	assign pu_tile = probe_tile inside {TILE_PU_BOMB, TILE_PU_RADIUS, TILE_PU_POTENCY,
		TILE_PU_THROW, TILE_PU_LIFE, TILE_PU_SPEED};
	assign open_tile = pu_tile || (probe_tile inside {TILE_EMPTY, TILE_P1, TILE_P2,
		TILE_P1_INV, TILE_P2_INV});
	assign clear_x = probe_x;	// held until the next load.
	assign clear_y = probe_y;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= S_LOAD;
			player <= 1'b0;
			corner <= '0;
			probe_req <= 1'b0;
			tile_clear <= 1'b0;
			p1_result_valid <= 1'b0;
			p2_result_valid <= 1'b0;
			p1_passable <= '0;
			p2_passable <= '0;
		end
		else
		begin
			tile_clear <= 1'b0;
			p1_result_valid <= 1'b0;
			p2_result_valid <= 1'b0;
			case (state)
				S_LOAD:
					if (!probe_ack)	// previous cycle fully closed.
					begin
						probe_req <= 1'b1;
						state <= S_WAIT_ACK;
					end
				S_WAIT_ACK:
					if (probe_ack)
					begin
						probe_req <= 1'b0;
						tile_clear <= pu_tile;
						p1_result_valid <= !player;
						p2_result_valid <= player;
						if (player)
							p2_passable[corner] <= open_tile;
						else
							p1_passable[corner] <= open_tile;
						state <= S_RELEASE;
					end
				S_RELEASE:
					if (!probe_ack)
						state <= S_ADVANCE;
				S_ADVANCE:
				begin
					corner <= corner + CW'(1);
					if (corner == CW'(CORNERS - 1))
						player <= ~player;	// other player's turn.
					state <= S_LOAD;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == S_LOAD)
		begin
			probe_x <= point_x;
			probe_y <= point_y;
		end
		if (state == S_WAIT_ACK && probe_ack)
		begin
			result_tile <= probe_tile;
			result_blast <= probe_blast;
		end
	end

	coord_hold: assert property (@(posedge clock) disable iff (reset)
		probe_req && $past(probe_req) |-> $stable(probe_x) && $stable(probe_y));

	req_after_ack: assert property (@(posedge clock) disable iff (reset)
		$rose(probe_req) |-> !probe_ack);

endmodule

// ==== rtl/powerup_stats.sv ====
// Lives, speed and bomb stats of one player, updated from the corner probe results.
module powerup_stats (
	input logic clock,
	input logic reset,
	input logic result_valid,
	input arena_pkg::tile_id_t result_tile,
	input logic result_blast,
	input logic invincible,
	output arena_pkg::lives_t lives,
	output arena_pkg::speed_t speed,
	output arena_pkg::stat_t bombs,
	output arena_pkg::stat_t radius,
	output arena_pkg::stat_t potency,
	output logic hit
);
	import arena_pkg::*;

	logic take_hit;

	// hit also covers the cycle before the timer output rises.
	assign take_hit = result_valid & result_blast & ~invincible & ~hit;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			lives <= START_LIVES;
			speed <= START_SPEED;
			bombs <= '0;
			radius <= '0;
			potency <= '0;
			hit <= 1'b0;
		end
		else
		begin
			hit <= take_hit;
			if (take_hit)
			begin
				if (lives != '0)	// floor at zero.
					lives <= lives - lives_t'(1);
			end
			else if (result_valid && result_tile == TILE_PU_LIFE && lives < LIFE_CAP)
				lives <= lives + lives_t'(1);
			if (result_valid)
			begin
				case (result_tile)
					TILE_PU_BOMB:
						if (bombs < STAT_LIMIT)
							bombs <= bombs + stat_t'(1);
					TILE_PU_RADIUS:
						if (radius < STAT_LIMIT)
							radius <= radius + stat_t'(1);
					TILE_PU_POTENCY:
						if (potency < STAT_LIMIT)
							potency <= potency + stat_t'(1);
					TILE_PU_SPEED:
						if (speed < SPEED_LIMIT)
							speed <= speed + speed_t'(1);
					default:
						;	// throw and non power-up tiles.
				endcase
			end
		end
	end

	stat_limits: assert property (@(posedge clock) disable iff (reset)
		bombs <= STAT_LIMIT && radius <= STAT_LIMIT && potency <= STAT_LIMIT &&
		speed <= SPEED_LIMIT);

endmodule

// ==== rtl/invincibility_timer.sv ====
// Invincibility window after a hit; counts down a fixed number of clock ticks.
module invincibility_timer #(
	parameter int unsigned TICKS = 40
) (
	input logic clock,
	input logic reset,
	input logic start,
	output logic invincible
);
	localparam int CW = $clog2(TICKS + 1);

	logic [CW-1:0] count;	// ticks left in the window.

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (start)
			count <= CW'(TICKS);
		else if (count != '0)
			count <= count - CW'(1);
	end

	assign invincible = (count != '0);

endmodule

// ==== rtl/arena_datapath.sv ====
// Player datapath top; two players share one corner prober on the tile map handshake.
module arena_datapath #(
	parameter int unsigned INV_TICKS = 40
) (
	input logic clock,
	input logic reset,
	input logic move_tick,
	input logic p1_xmov, p1_xdir, p1_ymov, p1_ydir,
	input logic p2_xmov, p2_xdir, p2_ymov, p2_ydir,
	input logic probe_ack,
	input arena_pkg::tile_id_t probe_tile,
	input logic probe_blast,
	output logic probe_req,
	output arena_pkg::coord_t probe_x, probe_y,
	output logic tile_clear,
	output arena_pkg::coord_t clear_x, clear_y,
	output arena_pkg::coord_t p1_x, p1_y, p2_x, p2_y,
	output arena_pkg::lives_t p1_lives, p2_lives,
	output arena_pkg::speed_t p1_speed, p2_speed,
	output arena_pkg::stat_t p1_bombs, p1_radius, p1_potency,
	output arena_pkg::stat_t p2_bombs, p2_radius, p2_potency,
	output logic p1_invincible, p2_invincible
);
	import arena_pkg::*;

	logic [CORNERS-1:0] p1_passable;
	logic [CORNERS-1:0] p2_passable;
	logic p1_result_valid;
	logic p2_result_valid;
	tile_id_t result_tile;	// shared, qualified per player.
	logic result_blast;
	logic p1_hit;
	logic p2_hit;

	corner_prober prober (.*);

	player_mover #(.START_X(P1_START_X)) p1_mover (
		.clock, .reset, .move_tick,
		.xmov(p1_xmov), .xdir(p1_xdir), .ymov(p1_ymov), .ydir(p1_ydir),
		.passable(p1_passable), .speed(p1_speed), .pos_x(p1_x), .pos_y(p1_y)
	);

	player_mover #(.START_X(P2_START_X)) p2_mover (
		.clock, .reset, .move_tick,
		.xmov(p2_xmov), .xdir(p2_xdir), .ymov(p2_ymov), .ydir(p2_ydir),
		.passable(p2_passable), .speed(p2_speed), .pos_x(p2_x), .pos_y(p2_y)
	);

	powerup_stats p1_stats (
		.clock, .reset, .result_valid(p1_result_valid), .result_tile, .result_blast,
		.invincible(p1_invincible), .lives(p1_lives), .speed(p1_speed),
		.bombs(p1_bombs), .radius(p1_radius), .potency(p1_potency), .hit(p1_hit)
	);

	powerup_stats p2_stats (
		.clock, .reset, .result_valid(p2_result_valid), .result_tile, .result_blast,
		.invincible(p2_invincible), .lives(p2_lives), .speed(p2_speed),
		.bombs(p2_bombs), .radius(p2_radius), .potency(p2_potency), .hit(p2_hit)
	);

	invincibility_timer #(.TICKS(INV_TICKS)) p1_timer (
		.clock, .reset, .start(p1_hit), .invincible(p1_invincible)
	);

	invincibility_timer #(.TICKS(INV_TICKS)) p2_timer (
		.clock, .reset, .start(p2_hit), .invincible(p2_invincible)
	);

endmodule

// ==== sim/tile_map_model.sv ====
// Testbench tile map; answers the probe handshake after a random delay and applies clears and writes.
module tile_map_model (
	input logic clock,
	input logic reset,
	input logic probe_req,
	input arena_pkg::coord_t probe_x,
	input arena_pkg::coord_t probe_y,
	output logic probe_ack,
	output arena_pkg::tile_id_t probe_tile,
	output logic probe_blast,
	input logic tile_clear,
	input arena_pkg::coord_t clear_x,
	input arena_pkg::coord_t clear_y,
	input logic write_en,
	input arena_pkg::coord_t write_x,
	input arena_pkg::coord_t write_y,
	input arena_pkg::tile_id_t write_tile
);
	timeunit 1ns;
	timeprecision 100ps;
	import arena_pkg::*;

	tile_id_t cells [0:10][0:10];	// 16 pixel tiles from (72,32).
	integer seed = 32'hb8b9;
	logic busy;
	logic [1:0] delay;	// cycles left before the answer.

	function automatic logic on_map(coord_t x, coord_t y);
		return x >= 9'd72 && x < 9'd248 && y >= 9'd32 && y < 9'd208;
	endfunction

	function automatic tile_id_t lookup(coord_t x, coord_t y);
		logic [3:0] c;
		logic [3:0] r;
		c = 4'((x - 9'd72) >> 4);
		r = 4'((y - 9'd32) >> 4);
		if (!on_map(x, y))
			return TILE_WALL;	// outside the arena.
		return cells[c][r];
	endfunction

	always @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			probe_ack <= 1'b0;
			probe_tile <= TILE_EMPTY;
			probe_blast <= 1'b0;
			busy <= 1'b0;
			delay <= 2'd0;
			for (int c = 0; c < 11; c++)
				for (int r = 0; r < 11; r++)
					cells[4'(c)][4'(r)] <= (c == 4) ? TILE_WALL : TILE_EMPTY;	// x 136 to 151.
		end
		else
		begin
			if (tile_clear && on_map(clear_x, clear_y))
				cells[4'((clear_x - 9'd72) >> 4)][4'((clear_y - 9'd32) >> 4)] <= TILE_EMPTY;
			if (write_en && on_map(write_x, write_y))
				cells[4'((write_x - 9'd72) >> 4)][4'((write_y - 9'd32) >> 4)] <= write_tile;
			if (probe_ack && !probe_req)
			begin
				probe_ack <= 1'b0;
				busy <= 1'b0;
			end
			else if (probe_req && !probe_ack && !busy)
			begin
				busy <= 1'b1;
				delay <= 2'($random(seed));	// 0 to 3 cycles.
			end
			else if (busy && !probe_ack)
			begin
				if (delay == 2'd0)
				begin
					probe_ack <= 1'b1;
					probe_tile <= lookup(probe_x, probe_y);
					probe_blast <= lookup(probe_x, probe_y) == TILE_EXPLOSION;
				end
				else
					delay <= delay - 2'd1;
			end
		end
	end

endmodule

// ==== sim/tb_arena_datapath.sv ====
// Testbench top for the arena datapath; drives keys and map tiles while assertions check the DUT.
module tb_arena_datapath;
	timeunit 1ns;
	timeprecision 100ps;
	import arena_pkg::*;

	localparam int INV_TICKS = 40;
	localparam int MOVE_GAP = 300;	// longer than one full probe round.
	localparam int WAIT_LIMIT = 400;
	localparam int CYCLE_LIMIT = 20000;	// about twice the stimulus length.

	logic clock = 1'b0;
	logic reset;
	logic move_tick;
	logic p1_xmov, p1_xdir, p1_ymov, p1_ydir;
	logic p2_xmov, p2_xdir, p2_ymov, p2_ydir;
	logic probe_ack, probe_blast, probe_req, tile_clear;
	tile_id_t probe_tile;
	coord_t probe_x, probe_y, clear_x, clear_y;
	coord_t p1_x, p1_y, p2_x, p2_y;
	lives_t p1_lives, p2_lives;
	speed_t p1_speed, p2_speed;
	stat_t p1_bombs, p1_radius, p1_potency, p2_bombs, p2_radius, p2_potency;
	logic p1_invincible, p2_invincible;
	logic write_en;
	coord_t write_x, write_y;
	tile_id_t write_tile;

	int errors = 0;
	int cycles = 0;
	logic req_q;
	logic [3:0] probe_seq;	// player in bit 3, corner below.
	coord_t last_p1_x, last_p1_y, last_p2_x, last_p2_y, exp_x, exp_y;
	lives_t last_p1_lives;
	logic last_p1_inv;
	logic drop_q;
	speed_t exp_speed;
	stat_t exp_bombs, exp_radius, exp_potency;
	tile_id_t placed_kind;
	logic [3:0] placed_col, placed_row;

	arena_datapath #(.INV_TICKS(INV_TICKS)) dut (.*);
	tile_map_model map (.*);

	always #10 clock = ~clock;

	function automatic coord_t corner_x(logic [2:0] k, coord_t px);
		if (k[2])
			return k[1] ? px + 9'd16 : px - 9'd1;	// side columns.
		return k[0] ? px + 9'd15 : px;
	endfunction

	function automatic coord_t corner_y(logic [2:0] k, coord_t py);
		if (k[2])
			return k[0] ? py + 9'd15 : py;
		return k[1] ? py + 9'd16 : py - 9'd1;	// rows above and below.
	endfunction

	assign exp_x = probe_seq[3] ? corner_x(probe_seq[2:0], last_p2_x) :
		corner_x(probe_seq[2:0], last_p1_x);
	assign exp_y = probe_seq[3] ? corner_y(probe_seq[2:0], last_p2_y) :
		corner_y(probe_seq[2:0], last_p1_y);

	always @(posedge clock)
	begin
		last_p1_x <= p1_x;
		last_p1_y <= p1_y;
		last_p2_x <= p2_x;
		last_p2_y <= p2_y;
		last_p1_lives <= p1_lives;
		last_p1_inv <= p1_invincible;
		drop_q <= p1_lives != last_p1_lives;
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	// expected stats follow the clears of the tile placed under player 1.
	always @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			req_q <= 1'b0;
			probe_seq <= 4'd0;
			exp_speed <= 4'd4;
			exp_bombs <= 2'd0;
			exp_radius <= 2'd0;
			exp_potency <= 2'd0;
		end
		else
		begin
			req_q <= probe_req;
			if (probe_req && !req_q)
				probe_seq <= probe_seq + 4'd1;
			if (tile_clear && placed_kind == TILE_PU_SPEED && exp_speed < 4'd8)
				exp_speed <= exp_speed + 4'd1;
			if (tile_clear && placed_kind == TILE_PU_BOMB && exp_bombs < 2'd2)
				exp_bombs <= exp_bombs + 2'd1;
			if (tile_clear && placed_kind == TILE_PU_RADIUS && exp_radius < 2'd2)
				exp_radius <= exp_radius + 2'd1;
			if (tile_clear && placed_kind == TILE_PU_POTENCY && exp_potency < 2'd2)
				exp_potency <= exp_potency + 2'd1;
		end
	end

	task automatic count_error(string text);
		errors++;
		$display("%s", text);
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
			$display("ERROR %s expected %h got %h", name, expected, actual);
	endtask

	task automatic show_reset_state();
		check_value("p1_x", 32'd88, 32'(p1_x));
		check_value("p1_y", 32'd112, 32'(p1_y));
		check_value("p2_x", 32'd216, 32'(p2_x));
		check_value("p2_y", 32'd112, 32'(p2_y));
		check_value("p1_lives", 32'd3, 32'(p1_lives));
		check_value("p2_lives", 32'd3, 32'(p2_lives));
		check_value("p1_speed", 32'd4, 32'(p1_speed));
		check_value("p2_speed", 32'd4, 32'(p2_speed));
		check_value("p1_stats", 32'd0, 32'({p1_bombs, p1_radius, p1_potency}));
		check_value("p2_stats", 32'd0, 32'({p2_bombs, p2_radius, p2_potency}));
		check_value("invincible", 32'd0, 32'({p1_invincible, p2_invincible}));
		check_value("probe_req", 32'd0, 32'(probe_req));
	endtask

	reset_state: assert property (@(posedge clock) $fell(reset) |->
		p1_x == 9'd88 && p1_y == 9'd112 && p2_x == 9'd216 && p2_y == 9'd112 &&
		p1_lives == 2'd3 && p2_lives == 2'd3 && p1_speed == 4'd4 && p2_speed == 4'd4 &&
		{p1_bombs, p1_radius, p1_potency, p2_bombs, p2_radius, p2_potency} == 12'd0 &&
		!p1_invincible && !p2_invincible && !probe_req)
		else
		begin
			errors++;
			show_reset_state();
		end

	probe_point: assert property (@(posedge clock) disable iff (reset)
		$rose(probe_req) |-> probe_x == exp_x && probe_y == exp_y)
		else count_error($sformatf("ERROR probe_x/probe_y expected %h/%h got %h/%h",
			$sampled(exp_x), $sampled(exp_y), $sampled(probe_x), $sampled(probe_y)));

	// player 2 picks up nothing, so it keeps the start speed of 4.
	p2_step: assert property (@(posedge clock) disable iff (reset)
		p2_x != last_p2_x |-> p2_x == last_p2_x - 9'd4)
		else count_error($sformatf("ERROR p2_x expected %h got %h",
			$sampled(last_p2_x) - 9'd4, $sampled(p2_x)));

	p2_clear_of_wall: assert property (@(posedge clock) disable iff (reset)
		(p2_x >= 9'd152 || p2_x + 9'd15 < 9'd136) && p2_x >= 9'd72 && p2_x <= 9'd232)
		else count_error("player 2 entered the wall or left the arena");

	speed_level: assert property (@(posedge clock) disable iff (reset) p1_speed == exp_speed)
		else count_error($sformatf("ERROR p1_speed expected %h got %h",
			$sampled(exp_speed), $sampled(p1_speed)));
	bombs_level: assert property (@(posedge clock) disable iff (reset) p1_bombs == exp_bombs)
		else count_error($sformatf("ERROR p1_bombs expected %h got %h",
			$sampled(exp_bombs), $sampled(p1_bombs)));
	radius_level: assert property (@(posedge clock) disable iff (reset) p1_radius == exp_radius)
		else count_error($sformatf("ERROR p1_radius expected %h got %h",
			$sampled(exp_radius), $sampled(p1_radius)));
	potency_level: assert property (@(posedge clock) disable iff (reset)
		p1_potency == exp_potency)
		else count_error($sformatf("ERROR p1_potency expected %h got %h",
			$sampled(exp_potency), $sampled(p1_potency)));

	clear_spot: assert property (@(posedge clock) disable iff (reset) tile_clear |->
		4'((clear_x - 9'd72) >> 4) == placed_col && 4'((clear_y - 9'd32) >> 4) == placed_row)
		else count_error("tile_clear pointed at a tile that holds no power-up");

	// a life goes only one at a time, never while invincible.
	life_drop: assert property (@(posedge clock) disable iff (reset)
		p1_lives != last_p1_lives |-> p1_lives == last_p1_lives - 2'd1 && !p1_invincible)
		else count_error("player 1 lost a life while invincible or more than one");

	window_after_hit: assert property (@(posedge clock) disable iff (reset)
		p1_invincible && !last_p1_inv |-> drop_q)
		else count_error("p1_invincible rose without a lost life");

	task automatic move_ticks(int count);
		repeat (count)
		begin
			repeat (MOVE_GAP - 1) @(posedge clock);
			move_tick <= 1'b1;
			@(posedge clock);
			move_tick <= 1'b0;
		end
	endtask

	task automatic place_tile(tile_id_t kind);
		@(posedge clock);
		placed_kind <= kind;
		placed_col <= 4'd1;	// tile under corners 0 and 1 of player 1.
		placed_row <= 4'd4;
		write_en <= 1'b1;
		write_x <= 9'd88;
		write_y <= 9'd111;
		write_tile <= kind;
		@(posedge clock);
		write_en <= 1'b0;
	endtask

	task automatic pick_up(tile_id_t kind);
		int n;
		n = 0;
		place_tile(kind);
		@(negedge clock);
		while (!tile_clear && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (!tile_clear)
		begin
			errors++;
			$display("no tile_clear came for the power-up under player 1");
		end
		repeat (3) @(negedge clock);
	endtask

	task automatic wait_invincible(logic level);
		int n;
		n = 0;
		@(negedge clock);
		while (p1_invincible !== level && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (p1_invincible !== level)
		begin
			errors++;
			$display("p1_invincible never reached %0d", level);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		move_tick = 1'b0;
		{p1_xmov, p1_xdir, p1_ymov, p1_ydir} = 4'b0;
		{p2_xmov, p2_xdir, p2_ymov, p2_ydir} = 4'b0;
		write_en = 1'b0;
		write_x = 9'd0;
		write_y = 9'd0;
		write_tile = TILE_EMPTY;
		placed_kind = TILE_EMPTY;
		placed_col = 4'd0;
		placed_row = 4'd0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		p2_xmov <= 1'b1;	// hold left until the wall stops it.
		p2_xdir <= 1'b0;
		move_ticks(19);
		p2_xmov <= 1'b0;
		@(negedge clock);
		assert (p2_x == 9'd152)
			else count_error($sformatf("ERROR p2_x expected %h got %h", 9'd152, p2_x));
		repeat (5) pick_up(TILE_PU_SPEED);
		repeat (3) pick_up(TILE_PU_BOMB);
		repeat (3) pick_up(TILE_PU_RADIUS);
		repeat (3) pick_up(TILE_PU_POTENCY);
		place_tile(TILE_EXPLOSION);
		wait_invincible(1'b1);
		assert (p1_lives == 2'd2)
			else count_error($sformatf("ERROR p1_lives expected %h got %h", 2'd2, p1_lives));
		wait_invincible(1'b0);
		wait_invincible(1'b1);	// explosion still there.
		assert (p1_lives == 2'd1)
			else count_error($sformatf("ERROR p1_lives expected %h got %h", 2'd1, p1_lives));
		place_tile(TILE_EMPTY);
		wait_invincible(1'b0);
		repeat (10) @(negedge clock);
		$display("run complete: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/arena_pkg.sv
rtl/coordinate_counter.sv
rtl/player_mover.sv
rtl/corner_prober.sv
rtl/powerup_stats.sv
rtl/invincibility_timer.sv
rtl/arena_datapath.sv
sim/tile_map_model.sv
sim/tb_arena_datapath.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --assert -j 0
TOP = tb_arena_datapath
FILELIST = files.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "** PASS **"

clean:
	rm -rf $(OBJ_DIR)
